//--- flist.f
design/simmem_pkg.sv
design/simmem_slot_table.sv
design/simmem_age_matrix.sv
design/simmem_beat_scheduler.sv
design/simmem_rank_timer.sv
design/simmem_release_tracker.sv
design/simmem_delay_calc.sv
sim/tb_simmem_delay_calc.sv

//--- Bender.yml
package:
  name: simmem_delay_calc

sources:
  - files:
      - design/simmem_pkg.sv
      - design/simmem_slot_table.sv
      - design/simmem_age_matrix.sv
      - design/simmem_beat_scheduler.sv
      - design/simmem_rank_timer.sv
      - design/simmem_release_tracker.sv
      - design/simmem_delay_calc.sv
  - target: test
    files:
      - sim/tb_simmem_delay_calc.sv

//--- sim/tb_simmem_delay_calc.sv
// Directed testbench for the DRAM rank delay model and top module of the flist.f build
`timescale 1ns/1ps

module tb_simmem_delay_calc;

  localparam int unsigned NumWSlots = 4;
  localparam int unsigned NumRSlots = 4;
  localparam int unsigned IidWidth = 3;
  localparam int unsigned NumIids = 2 ** IidWidth;
  localparam int unsigned AddrWidth = 20;
  localparam int unsigned RowLsb = 10;
  localparam int unsigned MaxBurstLen = 8;
  // Rank cost rule in cycles
  localparam int unsigned HitCycles = 4;
  localparam int unsigned ActCycles = 3;
  localparam int unsigned PreCycles = 3;
  localparam int unsigned WorstBeat = HitCycles + ActCycles + PreCycles + 1;
  localparam int unsigned WaitLimit = (NumWSlots + NumRSlots) * MaxBurstLen * WorstBeat + 20;

  logic clk_i;
  logic rst_ni;
  logic waddr_valid;
  logic waddr_ready;
  logic [IidWidth-1:0] waddr_iid;
  logic [AddrWidth-1:0] waddr_addr;
  logic [2:0] waddr_size;
  logic [3:0] waddr_len;
  logic raddr_valid;
  logic raddr_ready;
  logic [IidWidth-1:0] raddr_iid;
  logic [AddrWidth-1:0] raddr_addr;
  logic [2:0] raddr_size;
  logic [3:0] raddr_len;
  logic [NumIids-1:0] wresp_release_en;
  logic [NumIids-1:0] rdata_release_en;
  logic [NumIids-1:0] wresp_released;
  logic [NumIids-1:0] rdata_released;

  int cycle = 0;
  int errors = 0;
  int timeouts = 0;
  logic [31:0] lfsr = 32'hef13;
  // Open row as the testbench expects it
  logic model_row_open;
  logic [AddrWidth-RowLsb-1:0] model_row;
  // Iids still waiting for release in the random test
  logic [NumIids-1:0] w_out;
  logic [NumIids-1:0] r_out;

  simmem_delay_calc #(
    .NumWSlots (NumWSlots),
    .NumRSlots (NumRSlots),
    .WIidWidth (IidWidth),
    .RIidWidth (IidWidth)
  ) u_simmem_delay_calc (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .i_waddr_valid (waddr_valid), .o_waddr_ready (waddr_ready),
    .i_waddr_iid (waddr_iid), .i_waddr_addr (waddr_addr),
    .i_waddr_size (waddr_size), .i_waddr_len (waddr_len),
    .i_raddr_valid (raddr_valid), .o_raddr_ready (raddr_ready),
    .i_raddr_iid (raddr_iid), .i_raddr_addr (raddr_addr),
    .i_raddr_size (raddr_size), .i_raddr_len (raddr_len),
    .o_wresp_release_en (wresp_release_en), .o_rdata_release_en (rdata_release_en),
    .i_wresp_released (wresp_released), .i_rdata_released (rdata_released)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
  end

  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] value;
    logic fb;
    value = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      value = {value[30:0], fb};
    end
    return value;
  endfunction

  function automatic string dir_name(input logic is_read);
    return is_read ? "read" : "write";
  endfunction

  function automatic logic [NumIids-1:0] release_vec(input logic is_read);
    return is_read ? rdata_release_en : wresp_release_en;
  endfunction

  // Cycles from acceptance to release for a burst alone on the rank in beat order
  function automatic int burst_cycles(input logic [AddrWidth-1:0] addr, input int size,
                                      input int len);
    logic [AddrWidth-1:0] beat_addr;
    logic [AddrWidth-RowLsb-1:0] row;
    int total;
    total = 1;
    for (int b = 0; b < len; b++) begin
      beat_addr = addr + (AddrWidth'(b) << size);
      row = beat_addr[AddrWidth-1:RowLsb];
      if (!model_row_open) begin
        total += HitCycles + ActCycles + 1;
      end else if (row == model_row) begin
        total += HitCycles + 1;
      end else begin
        total += HitCycles + ActCycles + PreCycles + 1;
      end
      model_row_open = 1'b1;
      model_row = row;
    end
    return total;
  endfunction

  task automatic reset_dut();
    rst_ni = 1'b0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    model_row_open = 1'b0;
    model_row = '0;
  endtask

  task automatic drive_req(input logic is_read, input logic valid, input int iid,
                           input logic [AddrWidth-1:0] addr, input logic [2:0] size,
                           input logic [3:0] len);
    if (is_read) begin
      raddr_valid = valid;
      raddr_iid = IidWidth'(iid);
      raddr_addr = addr;
      raddr_size = size;
      raddr_len = len;
    end else begin
      waddr_valid = valid;
      waddr_iid = IidWidth'(iid);
      waddr_addr = addr;
      waddr_size = size;
      waddr_len = len;
    end
  endtask

  // Returns the cycle of the acceptance edge or -1 when never accepted
  task automatic send_req(input logic is_read, input int iid, input logic [AddrWidth-1:0] addr,
                          input logic [2:0] size, input logic [3:0] len, output int acc);
    int waited;
    waited = 0;
    drive_req(is_read, 1'b1, iid, addr, size, len);
    while (!(is_read ? raddr_ready : waddr_ready) && waited < WaitLimit) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (is_read ? raddr_ready : waddr_ready) begin
      @(posedge clk_i);
      #1;
      acc = cycle;
    end else begin
      timeouts++;
      $display("Timeout: %s iid %0d was never accepted", dir_name(is_read), iid);
      acc = -1;
    end
    drive_req(is_read, 1'b0, 0, '0, '0, '0);
  endtask

  task automatic wait_release(input logic is_read, input int iid, output int seen);
    logic [NumIids-1:0] vec;
    int waited;
    waited = 0;
    seen = -1;
    while (seen < 0 && waited < WaitLimit) begin
      @(posedge clk_i);
      #1;
      waited++;
      vec = release_vec(is_read);
      if (vec[iid]) begin
        seen = cycle;
      end
    end
    if (seen < 0) begin
      timeouts++;
      $display("Timeout: %s iid %0d never released", dir_name(is_read), iid);
    end
  endtask

  task automatic first_release(input logic is_read, input int iid_a, input int iid_b,
                               output int first);
    logic [NumIids-1:0] vec;
    int waited;
    waited = 0;
    first = -1;
    while (first < 0 && waited < WaitLimit) begin
      @(posedge clk_i);
      #1;
      waited++;
      vec = release_vec(is_read);
      if (vec[iid_a]) begin
        first = iid_a;
      end else if (vec[iid_b]) begin
        first = iid_b;
      end
    end
    if (first < 0) begin
      timeouts++;
      $display("Timeout: neither %s iid %0d nor %0d released", dir_name(is_read), iid_a, iid_b);
    end
  endtask

  task automatic pulse_release(input logic is_read, input logic [NumIids-1:0] mask);
    if (is_read) begin
      rdata_released = mask;
    end else begin
      wresp_released = mask;
    end
    @(posedge clk_i);
    #1;
    rdata_released = '0;
    wresp_released = '0;
  endtask

  task automatic check_latency(input logic is_read, input int iid,
                               input logic [AddrWidth-1:0] addr, input int size, input int len);
    int expected;
    int acc;
    int seen;
    expected = burst_cycles(addr, size, len);
    send_req(is_read, iid, addr, 3'(size), 4'(len), acc);
    wait_release(is_read, iid, seen);
    if (acc >= 0 && seen >= 0 && seen - acc != expected) begin
      errors++;
      $display("ERROR at %0t: %s iid %0d released %0d cycles after acceptance, expected %0d",
               $time, dir_name(is_read), iid, seen - acc, expected);
    end
    pulse_release(is_read, NumIids'(1) << iid);
  endtask

  task automatic reset_and_single_beats();
    reset_dut();
    if (!waddr_ready || !raddr_ready || wresp_release_en != '0 || rdata_release_en != '0) begin
      errors++;
      $display("ERROR at %0t: after reset ready w=%b r=%b release w=%h r=%h", $time,
               waddr_ready, raddr_ready, wresp_release_en, rdata_release_en);
    end
    // A closed row followed by a hit and a row conflict
    check_latency(1'b0, 0, 20'h01410, 2, 1);
    check_latency(1'b0, 1, 20'h01480, 2, 1);
    check_latency(1'b0, 2, 20'h02440, 2, 1);
  endtask

  task automatic burst_latency();
    reset_dut();
    check_latency(1'b0, 4, 20'h03000, 2, 4);
  endtask

  task automatic cost_priority();
    int acc;
    int first;
    int seen;
    // The write keeps the rank busy while both reads arrive
    reset_dut();
    send_req(1'b0, 0, 20'h00C00, 3'd2, 4'd1, acc);
    send_req(1'b1, 1, 20'h01800, 3'd2, 4'd1, acc);
    send_req(1'b1, 2, 20'h00C40, 3'd2, 4'd1, acc);
    first_release(1'b1, 1, 2, first);
    if (first >= 0 && first != 2) begin
      errors++;
      $display("ERROR at %0t: read iid %0d released first, expected the row hit iid 2",
               $time, first);
    end
    wait_release(1'b1, 1, seen);
    pulse_release(1'b1, 8'h06);
    pulse_release(1'b0, 8'h01);
    // Equal cost goes by age
    // The write burst holds the rank until iid 4 takes the lower slot freed by iid 5
    reset_dut();
    send_req(1'b1, 5, 20'h00C00, 3'd2, 4'd1, acc);
    send_req(1'b0, 1, 20'h00C40, 3'd2, 4'd8, acc);
    send_req(1'b1, 3, 20'h00C80, 3'd2, 4'd1, acc);
    wait_release(1'b1, 5, seen);
    send_req(1'b1, 4, 20'h00CC0, 3'd2, 4'd1, acc);
    first_release(1'b1, 3, 4, first);
    if (first >= 0 && first != 3) begin
      errors++;
      $display("ERROR at %0t: read iid %0d released first, expected the older iid 3",
               $time, first);
    end
    wait_release(1'b1, 4, seen);
    wait_release(1'b0, 1, seen);
    pulse_release(1'b1, 8'h38);
    pulse_release(1'b0, 8'h02);
  endtask

  task automatic pool_full();
    int acc;
    int seen;
    int waited;
    logic got;
    for (int k = 0; k < NumWSlots; k++) begin
      send_req(1'b0, k, 20'h01C00 + AddrWidth'(k * 'h40), 3'd2, 4'd1, acc);
    end
    if (waddr_ready) begin
      errors++;
      $display("ERROR at %0t: write ready high with all write slots taken", $time);
    end
    waited = 0;
    got = 1'b0;
    while (!got && waited < WaitLimit) begin
      @(posedge clk_i);
      #1;
      waited++;
      if (wresp_release_en[0]) begin
        got = 1'b1;
        if (!waddr_ready) begin
          errors++;
          $display("ERROR at %0t: write ready low after the first release", $time);
        end
      end else if (waddr_ready) begin
        errors++;
        $display("ERROR at %0t: write ready high before any slot freed", $time);
      end
    end
    if (!got) begin
      timeouts++;
      $display("Timeout: first write of the full pool never released");
    end
    for (int k = 1; k < NumWSlots; k++) begin
      wait_release(1'b0, k, seen);
    end
    pulse_release(1'b0, NumIids'((1 << NumWSlots) - 1));
  endtask

  task automatic release_feedback();
    int acc;
    int seen;
    send_req(1'b0, 3, 20'h04000, 3'd2, 4'd1, acc);
    send_req(1'b0, 5, 20'h04100, 3'd2, 4'd1, acc);
    send_req(1'b1, 6, 20'h04200, 3'd2, 4'd1, acc);
    wait_release(1'b0, 3, seen);
    wait_release(1'b0, 5, seen);
    wait_release(1'b1, 6, seen);
    repeat (3) begin
      @(posedge clk_i);
      #1;
      if (wresp_release_en != 8'h28 || rdata_release_en != 8'h40) begin
        errors++;
        $display("ERROR at %0t: held release bits w=%h r=%h, expected w=28 r=40", $time,
                 wresp_release_en, rdata_release_en);
      end
    end
    pulse_release(1'b0, 8'h08);
    if (wresp_release_en != 8'h20 || rdata_release_en != 8'h40) begin
      errors++;
      $display("ERROR at %0t: release bits w=%h r=%h after clearing write iid 3", $time,
               wresp_release_en, rdata_release_en);
    end
    pulse_release(1'b0, 8'h20);
    pulse_release(1'b1, 8'h40);
    if (wresp_release_en != '0 || rdata_release_en != '0) begin
      errors++;
      $display("ERROR at %0t: release bits w=%h r=%h left after feedback", $time,
               wresp_release_en, rdata_release_en);
    end
  endtask

  // Clears releases as they come and flags any iid that was not outstanding
  task automatic drain_random(input int limit);
    logic [NumIids-1:0] wset;
    logic [NumIids-1:0] rset;
    int waited;
    waited = 0;
    while ((w_out != '0 || r_out != '0) && waited < limit) begin
      @(posedge clk_i);
      #1;
      waited++;
      wresp_released = '0;
      rdata_released = '0;
      wset = wresp_release_en;
      rset = rdata_release_en;
      if ((wset & ~w_out) != '0 || (rset & ~r_out) != '0) begin
        errors++;
        $display("ERROR at %0t: unexpected release w=%h r=%h, outstanding w=%h r=%h",
                 $time, wset, rset, w_out, r_out);
      end
      w_out = w_out & ~wset;
      r_out = r_out & ~rset;
      wresp_released = wset;
      rdata_released = rset;
    end
    @(posedge clk_i);
    #1;
    wresp_released = '0;
    rdata_released = '0;
    if (w_out != '0 || r_out != '0) begin
      timeouts++;
      $display("Timeout: random traffic left w=%h r=%h unreleased", w_out, r_out);
    end
  endtask

  task automatic random_traffic(input int waves, input int per_wave);
    logic is_read;
    logic [AddrWidth-1:0] addr;
    logic [2:0] size;
    logic [3:0] len;
    logic [31:0] row_bits;
    logic [31:0] col_bits;
    int wn;
    int rn;
    int limit;
    int acc;
    for (int w = 0; w < waves; w++) begin
      wn = 0;
      rn = 0;
      limit = 20;
      w_out = '0;
      r_out = '0;
      for (int k = 0; k < per_wave; k++) begin
        is_read = rand_bits(1);
        row_bits = rand_bits(2);
        col_bits = rand_bits(RowLsb);
        addr = (AddrWidth'(row_bits) << RowLsb) | AddrWidth'(col_bits);
        len = 4'(rand_bits(3)) + 4'd1;
        size = 3'(rand_bits(2));
        limit += len * WorstBeat + 2;
        send_req(is_read, is_read ? rn : wn, addr, size, len, acc);
        if (acc >= 0 && is_read) begin
          r_out[rn] = 1'b1;
        end else if (acc >= 0) begin
          w_out[wn] = 1'b1;
        end
        if (is_read) begin
          rn++;
        end else begin
          wn++;
        end
      end
      drain_random(limit);
    end
  endtask

  initial begin
    rst_ni = 1'b0;
    drive_req(1'b0, 1'b0, 0, '0, '0, '0);
    drive_req(1'b1, 1'b0, 0, '0, '0, '0);
    wresp_released = '0;
    rdata_released = '0;
    model_row_open = 1'b0;
    model_row = '0;
    w_out = '0;
    r_out = '0;

    reset_and_single_beats();
    burst_latency();
    cost_priority();
    pool_full();
    release_feedback();
    random_traffic(4, 6);

    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- design/simmem_delay_calc.sv
// Top of the DRAM rank delay model; accepts address requests and raises per-iid release bits
`timescale 1ns/1ps

module simmem_delay_calc #(
  parameter int unsigned NumWSlots = 4,
  parameter int unsigned NumRSlots = 4,
  parameter int unsigned WIidWidth = 3,
  parameter int unsigned RIidWidth = 3
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic i_waddr_valid,
  output logic o_waddr_ready,
  input  logic [WIidWidth-1:0] i_waddr_iid,
  input  logic [simmem_pkg::AddrWidth-1:0] i_waddr_addr,
  input  logic [simmem_pkg::SizeWidth-1:0] i_waddr_size,
  input  logic [simmem_pkg::BurstLenWidth-1:0] i_waddr_len,
  input  logic i_raddr_valid,
  output logic o_raddr_ready,
  input  logic [RIidWidth-1:0] i_raddr_iid,
  input  logic [simmem_pkg::AddrWidth-1:0] i_raddr_addr,
  input  logic [simmem_pkg::SizeWidth-1:0] i_raddr_size,
  input  logic [simmem_pkg::BurstLenWidth-1:0] i_raddr_len,
  output logic [2**WIidWidth-1:0] o_wresp_release_en,
  output logic [2**RIidWidth-1:0] o_rdata_release_en,
  input  logic [2**WIidWidth-1:0] i_wresp_released,
  input  logic [2**RIidWidth-1:0] i_rdata_released
);

  import simmem_pkg::*;

  localparam int unsigned NumSlots = NumWSlots + NumRSlots;
  localparam int unsigned AgeLen = NumSlots * (NumSlots - 1) / 2;

  logic [NumWSlots-1:0] w_alloc_onehot;
  logic [NumWSlots-1:0][MaxBurstLen-1:0] w_ready_beats;
  logic [NumWSlots-1:0][AddrWidth-1:0] w_slot_addr;
  logic [NumWSlots-1:0][SizeWidth-1:0] w_slot_size;
  logic w_complete;
  logic [WIidWidth-1:0] w_complete_iid;

  logic [NumRSlots-1:0] r_alloc_onehot;
  logic [NumRSlots-1:0][MaxBurstLen-1:0] r_ready_beats;
  logic [NumRSlots-1:0][AddrWidth-1:0] r_slot_addr;
  logic [NumRSlots-1:0][SizeWidth-1:0] r_slot_size;
  logic r_complete;
  logic [RIidWidth-1:0] r_complete_iid;

  logic [AgeLen-1:0] older;
  logic w_issue;
  logic r_issue;
  logic [NumSlots-1:0] issue_slot_onehot;
  logic [BeatIdxWidth-1:0] issue_beat;
  logic [AddrWidth-1:0] issue_addr;
  cost_e issue_cost;

  logic idle;
  logic done;
  logic row_open;
  logic [RowWidth-1:0] open_row;

  simmem_slot_table #(
    .NumSlots (NumWSlots),
    .IidWidth (WIidWidth)
  ) u_w_slots (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .i_valid (i_waddr_valid), .i_iid (i_waddr_iid),
    .i_addr (i_waddr_addr), .i_size (i_waddr_size), .i_len (i_waddr_len),
    .i_issue (w_issue),
    .i_issue_slot_onehot (issue_slot_onehot[NumWSlots-1:0]),
    .i_issue_beat (issue_beat), .i_done (done),
    .o_ready (o_waddr_ready), .o_alloc_onehot (w_alloc_onehot),
    .o_ready_beats (w_ready_beats),
    .o_slot_addr (w_slot_addr), .o_slot_size (w_slot_size),
    .o_complete (w_complete), .o_complete_iid (w_complete_iid)
  );

  simmem_slot_table #(
    .NumSlots (NumRSlots),
    .IidWidth (RIidWidth)
  ) u_r_slots (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .i_valid (i_raddr_valid), .i_iid (i_raddr_iid),
    .i_addr (i_raddr_addr), .i_size (i_raddr_size), .i_len (i_raddr_len),
    .i_issue (r_issue),
    .i_issue_slot_onehot (issue_slot_onehot[NumSlots-1:NumWSlots]),
    .i_issue_beat (issue_beat), .i_done (done),
    .o_ready (o_raddr_ready), .o_alloc_onehot (r_alloc_onehot),
    .o_ready_beats (r_ready_beats),
    .o_slot_addr (r_slot_addr), .o_slot_size (r_slot_size),
    .o_complete (r_complete), .o_complete_iid (r_complete_iid)
  );

  // Write slots first, so a write allocated with a read counts as older
  simmem_age_matrix #(
    .NumSlots (NumSlots)
  ) u_age (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .i_alloc_onehot ({r_alloc_onehot, w_alloc_onehot}),
    .o_older (older)
  );

  simmem_beat_scheduler #(
    .NumWSlots (NumWSlots),
    .NumRSlots (NumRSlots)
  ) u_sched (
    .i_idle (idle), .i_row_open (row_open), .i_open_row (open_row),
    .i_w_ready_beats (w_ready_beats),
    .i_w_slot_addr (w_slot_addr), .i_w_slot_size (w_slot_size),
    .i_r_ready_beats (r_ready_beats),
    .i_r_slot_addr (r_slot_addr), .i_r_slot_size (r_slot_size),
    .i_older (older),
    .o_w_issue (w_issue), .o_r_issue (r_issue),
    .o_issue_slot_onehot (issue_slot_onehot),
    .o_issue_beat (issue_beat), .o_issue_addr (issue_addr),
    .o_issue_cost (issue_cost)
  );

  simmem_rank_timer u_timer (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .i_issue (w_issue | r_issue),
    .i_issue_addr (issue_addr), .i_issue_cost (issue_cost),
    .o_idle (idle), .o_done (done),
    .o_row_open (row_open), .o_open_row (open_row)
  );

  simmem_release_tracker #(
    .IidWidth (WIidWidth)
  ) u_w_release (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .i_complete (w_complete), .i_complete_iid (w_complete_iid),
    .i_released (i_wresp_released),
    .o_release_en (o_wresp_release_en)
  );

  simmem_release_tracker #(
    .IidWidth (RIidWidth)
  ) u_r_release (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .i_complete (r_complete), .i_complete_iid (r_complete_iid),
    .i_released (i_rdata_released),
    .o_release_en (o_rdata_release_en)
  );

endmodule

//--- design/simmem_release_tracker.sv
// Release enable bits per iid, set on burst completion and cleared by the bank's release pulse
`timescale 1ns/1ps

module simmem_release_tracker #(
  parameter int unsigned IidWidth = 3
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic i_complete,
  input  logic [IidWidth-1:0] i_complete_iid,
  input  logic [2**IidWidth-1:0] i_released,
  output logic [2**IidWidth-1:0] o_release_en
);

  localparam int unsigned Capacity = 2 ** IidWidth;

  logic [Capacity-1:0] set_onehot;
  logic [Capacity-1:0] release_en_q;

  assign set_onehot = {{(Capacity-1){1'b0}}, i_complete} << i_complete_iid;

  // Set wins if both hit the same iid
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      release_en_q <= '0;
    end else begin
      release_en_q <= (release_en_q & ~i_released) | set_onehot;
    end
  end

  assign o_release_en = release_en_q;

endmodule

//--- design/simmem_rank_timer.sv
// Rank busy counter and open row register; flags the last busy cycle of each served beat
`timescale 1ns/1ps

module simmem_rank_timer (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic i_issue,
  input  logic [simmem_pkg::AddrWidth-1:0] i_issue_addr,
  input  simmem_pkg::cost_e i_issue_cost,
  output logic o_idle,
  output logic o_done,
  output logic o_row_open,
  output logic [simmem_pkg::RowWidth-1:0] o_open_row
);

  import simmem_pkg::*;

  logic [DelayWidth-1:0] cnt_q;
  logic row_open_q;
  logic [RowWidth-1:0] open_row_q;
  mem_addr_u issue_addr;

  assign issue_addr.flat = i_issue_addr;

  assign o_idle = cnt_q == '0;
  // Count of one means the beat finishes at the coming edge
  assign o_done = cnt_q == DelayWidth'(1);
  assign o_row_open = row_open_q;
  assign o_open_row = open_row_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
      row_open_q <= 1'b0;
      open_row_q <= '0;
    end else if (i_issue) begin
      cnt_q <= cost_cycles(i_issue_cost);
      row_open_q <= 1'b1;
      open_row_q <= issue_addr.rc.row;
    end else if (!o_idle) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

endmodule

//--- design/simmem_beat_scheduler.sv
// Picks the cheapest ready beat over both slot pools, oldest slot first, when the rank is idle
`timescale 1ns/1ps

module simmem_beat_scheduler #(
  parameter int unsigned NumWSlots = 4,
  parameter int unsigned NumRSlots = 4,
  localparam int unsigned NumSlots = NumWSlots + NumRSlots
) (
  input  logic i_idle,
  input  logic i_row_open,
  input  logic [simmem_pkg::RowWidth-1:0] i_open_row,
  input  logic [NumWSlots-1:0][simmem_pkg::MaxBurstLen-1:0] i_w_ready_beats,
  input  logic [NumWSlots-1:0][simmem_pkg::AddrWidth-1:0] i_w_slot_addr,
  input  logic [NumWSlots-1:0][simmem_pkg::SizeWidth-1:0] i_w_slot_size,
  input  logic [NumRSlots-1:0][simmem_pkg::MaxBurstLen-1:0] i_r_ready_beats,
  input  logic [NumRSlots-1:0][simmem_pkg::AddrWidth-1:0] i_r_slot_addr,
  input  logic [NumRSlots-1:0][simmem_pkg::SizeWidth-1:0] i_r_slot_size,
  input  logic [NumSlots*(NumSlots-1)/2-1:0] i_older,
  output logic o_w_issue,
  output logic o_r_issue,
  output logic [NumSlots-1:0] o_issue_slot_onehot,
  output logic [simmem_pkg::BeatIdxWidth-1:0] o_issue_beat,
  output logic [simmem_pkg::AddrWidth-1:0] o_issue_addr,
  output simmem_pkg::cost_e o_issue_cost
);

  import simmem_pkg::*;

  localparam int unsigned SlotIdxWidth = $clog2(NumSlots);

  // Writes sit in the low slot indices, reads above them
  logic [NumSlots-1:0][MaxBurstLen-1:0] ready_beats;
  logic [NumSlots-1:0][AddrWidth-1:0] slot_addr;
  logic [NumSlots-1:0][SizeWidth-1:0] slot_size;
  logic [NumSlots-1:0][NumSlots-1:0] older_than;

  logic slot_valid [NumSlots];
  cost_e slot_cost [NumSlots];
  logic [BeatIdxWidth-1:0] slot_beat [NumSlots];
  logic [AddrWidth-1:0] slot_beat_addr [NumSlots];

  logic found;
  logic issue;
  logic [SlotIdxWidth-1:0] best_slot;
  cost_e best_cost;

  assign ready_beats = {i_r_ready_beats, i_w_ready_beats};
  assign slot_addr = {i_r_slot_addr, i_w_slot_addr};
  assign slot_size = {i_r_slot_size, i_w_slot_size};

  function automatic cost_e classify(mem_addr_u addr, logic row_open,
                                     logic [RowWidth-1:0] open_row);
    if (!row_open) begin
      return COST_ACTIVATE;
    end
    if (addr.rc.row == open_row) begin
      return COST_HIT;
    end
    return COST_PRECHARGE;
  endfunction

  // Full age relation unfolded from the upper triangle
  for (genvar i = 0; i < NumSlots; i++) begin : gen_older_row
    for (genvar j = 0; j < NumSlots; j++) begin : gen_older_col
      if (i < j) begin : gen_upper
        assign older_than[i][j] = i_older[age_idx(NumSlots, i, j)];
      end else if (i > j) begin : gen_lower
        assign older_than[i][j] = ~i_older[age_idx(NumSlots, j, i)];
      end else begin : gen_diag
        assign older_than[i][j] = 1'b0;
      end
    end
  end

  // Cheapest beat within each slot, lowest beat wins a tie
  always_comb begin
    mem_addr_u beat_addr;
    cost_e beat_cost;
    for (int unsigned s = 0; s < NumSlots; s++) begin
      slot_valid[s] = 1'b0;
      slot_cost[s] = COST_PRECHARGE;
      slot_beat[s] = '0;
      slot_beat_addr[s] = '0;
      for (int unsigned b = 0; b < MaxBurstLen; b++) begin
        beat_addr.flat = slot_addr[s] + (AddrWidth'(b) << slot_size[s]);
        beat_cost = classify(beat_addr, i_row_open, i_open_row);
        if (ready_beats[s][b] && (!slot_valid[s] || beat_cost < slot_cost[s])) begin
          slot_valid[s] = 1'b1;
          slot_cost[s] = beat_cost;
          slot_beat[s] = BeatIdxWidth'(b);
          slot_beat_addr[s] = beat_addr.flat;
        end
      end
    end
  end

  // Cheapest slot overall, the older one on equal cost
  always_comb begin
    found = 1'b0;
    best_slot = '0;
    best_cost = COST_PRECHARGE;
    for (int unsigned s = 0; s < NumSlots; s++) begin
      if (slot_valid[s] && (!found || slot_cost[s] < best_cost ||
          (slot_cost[s] == best_cost && older_than[s][best_slot]))) begin
        found = 1'b1;
        best_slot = SlotIdxWidth'(s);
        best_cost = slot_cost[s];
      end
    end
  end

  assign issue = i_idle & found;
  assign o_w_issue = issue & (32'(best_slot) < NumWSlots);
  assign o_r_issue = issue & (32'(best_slot) >= NumWSlots);
  assign o_issue_slot_onehot = {{(NumSlots-1){1'b0}}, issue} << best_slot;
  assign o_issue_beat = slot_beat[best_slot];
  assign o_issue_addr = slot_beat_addr[best_slot];
  assign o_issue_cost = best_cost;

endmodule

//--- design/simmem_age_matrix.sv
// Pairwise age order of all write and read slots, read by the scheduler to break cost ties
`timescale 1ns/1ps

module simmem_age_matrix #(
  parameter int unsigned NumSlots = 8
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic [NumSlots-1:0] i_alloc_onehot,
  output logic [NumSlots*(NumSlots-1)/2-1:0] o_older
);

  import simmem_pkg::*;

  localparam int unsigned AgeLen = NumSlots * (NumSlots - 1) / 2;

  // Bit (i, j) with i < j is set when slot i is older than slot j
  logic [AgeLen-1:0] older_q;
  logic [AgeLen-1:0] older_d;

  always_comb begin
    older_d = older_q;
    for (int unsigned i = 0; i < NumSlots; i++) begin
      for (int unsigned j = i + 1; j < NumSlots; j++) begin
        // A new slot is younger than everything else
        if (i_alloc_onehot[j]) begin
          older_d[age_idx(NumSlots, i, j)] = 1'b1;
        end else if (i_alloc_onehot[i]) begin
          older_d[age_idx(NumSlots, i, j)] = 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      older_q <= '0;
    end else begin
      older_q <= older_d;
    end
  end

  assign o_older = older_q;

endmodule

//--- design/simmem_slot_table.sv
// Burst slot pool for one direction; holds accepted requests and tracks each beat until done
`timescale 1ns/1ps

module simmem_slot_table #(
  parameter int unsigned NumSlots = 4,
  parameter int unsigned IidWidth = 3
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic i_valid,
  input  logic [IidWidth-1:0] i_iid,
  input  logic [simmem_pkg::AddrWidth-1:0] i_addr,
  input  logic [simmem_pkg::SizeWidth-1:0] i_size,
  input  logic [simmem_pkg::BurstLenWidth-1:0] i_len,
  input  logic i_issue,
  input  logic [NumSlots-1:0] i_issue_slot_onehot,
  input  logic [simmem_pkg::BeatIdxWidth-1:0] i_issue_beat,
  input  logic i_done,
  output logic o_ready,
  output logic [NumSlots-1:0] o_alloc_onehot,
  output logic [NumSlots-1:0][simmem_pkg::MaxBurstLen-1:0] o_ready_beats,
  output logic [NumSlots-1:0][simmem_pkg::AddrWidth-1:0] o_slot_addr,
  output logic [NumSlots-1:0][simmem_pkg::SizeWidth-1:0] o_slot_size,
  output logic o_complete,
  output logic [IidWidth-1:0] o_complete_iid
);

  import simmem_pkg::*;

  logic [NumSlots-1:0] valid_q;
  logic [NumSlots-1:0] valid_d;
  logic [NumSlots-1:0][MaxBurstLen-1:0] pending_q;
  logic [NumSlots-1:0][MaxBurstLen-1:0] pending_d;
  logic [NumSlots-1:0][MaxBurstLen-1:0] done_q;
  logic [NumSlots-1:0][MaxBurstLen-1:0] done_d;
  logic [NumSlots-1:0][IidWidth-1:0] iid_q;
  logic [NumSlots-1:0][AddrWidth-1:0] addr_q;
  logic [NumSlots-1:0][SizeWidth-1:0] size_q;

  logic [NumSlots-1:0] free;
  logic [NumSlots-1:0] complete_mask;
  logic [NumSlots-1:0] complete_onehot;
  logic [MaxBurstLen-1:0] init_done;

  // Lowest free slot takes the next request
  assign free = ~valid_q;
  assign o_ready = |free;
  assign o_alloc_onehot = free & ~(free - 1'b1) & {NumSlots{i_valid}};

  // Beats beyond the burst length never go to the rank
  always_comb begin
    for (int unsigned b = 0; b < MaxBurstLen; b++) begin
      init_done[b] = BurstLenWidth'(b) >= i_len;
    end
  end

  for (genvar s = 0; s < NumSlots; s++) begin : gen_ready_beats
    assign o_ready_beats[s] = {MaxBurstLen{valid_q[s]}} & ~pending_q[s] & ~done_q[s];
    assign complete_mask[s] = valid_q[s] & (&done_q[s]);
  end

  assign o_slot_addr = addr_q;
  assign o_slot_size = size_q;

  // One finished burst reported per cycle, lowest slot first
  assign complete_onehot = complete_mask & ~(complete_mask - 1'b1);
  assign o_complete = |complete_mask;

  always_comb begin
    o_complete_iid = '0;
    for (int unsigned s = 0; s < NumSlots; s++) begin
      if (complete_onehot[s]) begin
        o_complete_iid = iid_q[s];
      end
    end
  end

  always_comb begin
    valid_d = valid_q;
    pending_d = pending_q;
    done_d = done_q;
    for (int unsigned s = 0; s < NumSlots; s++) begin
      if (complete_onehot[s]) begin
        valid_d[s] = 1'b0;
      end
      // Only one beat is ever in flight on the rank
      if (i_done) begin
        done_d[s] = done_q[s] | pending_q[s];
        pending_d[s] = '0;
      end
      if (i_issue && i_issue_slot_onehot[s]) begin
        pending_d[s][i_issue_beat] = 1'b1;
      end
      if (o_alloc_onehot[s]) begin
        valid_d[s] = 1'b1;
        pending_d[s] = '0;
        done_d[s] = init_done;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      pending_q <= '0;
      done_q <= '0;
    end else begin
      valid_q <= valid_d;
      pending_q <= pending_d;
      done_q <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int unsigned s = 0; s < NumSlots; s++) begin
      if (o_alloc_onehot[s]) begin
        iid_q[s] <= i_iid;
        addr_q[s] <= i_addr;
        size_q[s] <= i_size;
      end
    end
  end

endmodule

//--- design/simmem_pkg.sv
// Shared widths, DRAM cost constants and address types, imported by every simmem RTL module
package simmem_pkg;

  // Byte address and row buffer geometry
  localparam int unsigned AddrWidth = 20;
  localparam int unsigned RowBufferLenWidth = 10;
  localparam int unsigned RowWidth = AddrWidth - RowBufferLenWidth;

  // Burst description
  localparam int unsigned SizeWidth = 3;
  localparam int unsigned MaxBurstLen = 8;
  localparam int unsigned BurstLenWidth = 4;
  localparam int unsigned BeatIdxWidth = $clog2(MaxBurstLen);

  // Rank timing in cycles
  localparam int unsigned DelayWidth = 5;
  localparam int unsigned RowHitCost = 4;
  localparam int unsigned ActivationCost = 3;
  localparam int unsigned PrechargeCost = 3;

  typedef struct packed {
    logic [RowWidth-1:0] row;
    logic [RowBufferLenWidth-1:0] col;
  } mem_row_col_t;

  // Flat view for beat arithmetic, row/column view for row buffer hits
  typedef union packed {
    logic [AddrWidth-1:0] flat;
    mem_row_col_t rc;
  } mem_addr_u;

  // Cost classes, ordered cheapest first
  typedef enum logic [1:0] {
    COST_HIT = 2'd0,
    COST_ACTIVATE = 2'd1,
    COST_PRECHARGE = 2'd2
  } cost_e;

  function automatic logic [DelayWidth-1:0] cost_cycles(cost_e cost);
    case (cost)
      COST_HIT: return DelayWidth'(RowHitCost);
      COST_ACTIVATE: return DelayWidth'(RowHitCost + ActivationCost);
      default: return DelayWidth'(RowHitCost + ActivationCost + PrechargeCost);
    endcase
  endfunction

  // Bit position of pair (lo, hi) in an upper triangle age vector, lo < hi
  function automatic int unsigned age_idx(int unsigned side, int unsigned lo,
                                          int unsigned hi);
    return lo * side - (lo * (lo + 1)) / 2 + hi - lo - 1;
  endfunction

endpackage
